// File: bench/ecc_check_properties.sv
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_check_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     in_credit,
    input logic                     out_valid,
    input ecc_stream_pkg::ecc_out_s out_word,
    input logic                     out_credit
);
    int out_credits;    // shadow of the downstream counter
    int up_credits;     // credits the upstream holds

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_credits <= `ECC_OUT_CREDITS;
            up_credits  <= `ECC_FIFO_DEPTH;
        end else begin
            out_credits <= out_credits + int'(out_credit) - int'(out_valid);
            up_credits  <= up_credits + int'(in_credit) - int'(in_valid);
        end
    end

    // ==========================================================================
    // checks
    // ==========================================================================
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(out_word.sbit_err && out_word.dbit_err))
        else $error("sbit_err and dbit_err set together");

    a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high right after reset");

    a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_credits > 0)
        else $error("out_valid with no downstream credit");

    a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> up_credits > 0)
        else $error("in_valid with no upstream credit left");

endmodule

bind ecc_check_top ecc_check_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_word   (out_word),
    .out_credit (out_credit)
);

// File: bench/ecc_check_tb.sv
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_check_tb;
    import ecc_code_pkg::*;
    import ecc_stream_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    ecc_in_s  in_word;
    logic     in_credit;
    logic     out_valid;
    ecc_out_s out_word;
    logic     out_credit;

    ecc_out_s    exp_q[$];
    logic [15:0] stim_lfsr    = 16'd83;
    logic [15:0] credit_lfsr  = 16'd83;
    int          up_credits   = `ECC_FIFO_DEPTH;
    int          credit_owed  = 0;      // downstream credits not yet returned
    logic        hold_credits = 1'b0;
    int          words_sent   = 0;
    int          words_recv   = 0;
    int          cycles       = 0;
    int          checks       = 0;
    int          mismatches   = 0;
    int          other_errors = 0;

    ecc_check_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================================
    // random source and reference model
    // ==========================================================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [127:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            state = lfsr_next(state);
            v[b]  = state[0];
        end
    endtask

    // column of data bit idx, from its hamming position
    function automatic logic [7:0] data_column(input int idx);
        int         pos;
        int         found;
        logic [6:0] p;
        logic       even;
        pos   = 2;
        found = -1;
        while (found < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin   // powers of two hold check bits
                found++;
            end
        end
        p    = pos[6:0];
        even = ($countones(p) % 2) == 0;
        return {even, p};
    endfunction

    function automatic logic [7:0] ref_check(input ecc_data_t data);
        logic [7:0] chk;
        chk = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (data[i]) begin
                chk ^= data_column(i);
            end
        end
        return chk;
    endfunction

    function automatic ecc_out_s expected_result(input ecc_in_s w);
        ecc_out_s   r;
        logic [7:0] syn;
        int         hit;
        r.data     = w.data;
        r.check    = ref_check(w.data);
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        syn        = w.check ^ r.check;
        if (w.bypass || syn == '0) begin
            return r;
        end
        if ($countones(syn) == 1) begin     // check bit alone
            r.sbit_err = 1'b1;
            return r;
        end
        hit = -1;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (data_column(i) == syn) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            r.data[hit] = ~r.data[hit];
            r.sbit_err  = 1'b1;
        end else begin
            r.dbit_err = 1'b1;
        end
        return r;
    endfunction

    function automatic ecc_in_s encode(input ecc_data_t data, input logic bypass);
        ecc_in_s w;
        w.data   = data;
        w.check  = ref_check(data);
        w.bypass = bypass;
        return w;
    endfunction

    // k below 83 hits a data bit, above it a check bit
    function automatic ecc_in_s flip_bit(input ecc_in_s w, input int k);
        ecc_in_s f;
        f = w;
        if (k < `ECC_DATA_WIDTH) begin
            f.data[k] = ~f.data[k];
        end else begin
            f.check[k - `ECC_DATA_WIDTH] = ~f.check[k - `ECC_DATA_WIDTH];
        end
        return f;
    endfunction

    task automatic compare(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("FAIL time=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // ==========================================================================
    // upstream side
    // ==========================================================================
    task automatic send_word(input ecc_in_s w);
        while (up_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_word  = w;
        up_credits--;
        words_sent++;
        exp_q.push_back(expected_result(w));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || credit_owed != 0 || up_credits != `ECC_FIFO_DEPTH) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && in_credit === 1'b1) begin
            up_credits++;
        end
    end

    // ==========================================================================
    // downstream side
    // ==========================================================================
    always @(posedge clk) begin : scoreboard
        ecc_out_s exp;
        if (rst_n && out_valid === 1'b1) begin
            words_recv++;
            credit_owed++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("output word at time %0t with no word pending", $time);
            end else begin
                exp = exp_q.pop_front();
                compare("out_word.data", exp.data, out_word.data);
                compare("out_word.check", exp.check, out_word.check);
                compare("out_word.sbit_err", exp.sbit_err, out_word.sbit_err);
                compare("out_word.dbit_err", exp.dbit_err, out_word.dbit_err);
            end
        end
    end

    initial begin : credit_return
        int            delay;
        logic [127:0]  r;
        out_credit = 1'b0;
        delay      = 0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (rst_n && !hold_credits && credit_owed > 0) begin
                if (delay == 0) begin
                    out_credit = 1'b1;
                    credit_owed--;
                    draw_bits(credit_lfsr, 2, r);
                    delay = r[1:0];
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * words_sent + 200) begin
            $display("timeout after %0d cycles, %0d words never came out", cycles, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    // ==========================================================================
    // stimulus
    // ==========================================================================
    initial begin : stimulus
        logic [127:0] r;
        logic [127:0] r2;
        ecc_in_s      w;
        int           k1;
        int           k2;
        int           base;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int n = 0; n < 12; n++) begin      // clean words
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            send_word(encode(r[`ECC_DATA_WIDTH-1:0], 1'b0));
        end
        for (int n = 0; n < 12; n++) begin      // one data bit
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            draw_bits(stim_lfsr, 7, r2);
            k1 = (n == 0) ? 0 : (n == 1) ? `ECC_DATA_WIDTH - 1 : int'(r2[6:0]) % 83;
            send_word(flip_bit(encode(r[`ECC_DATA_WIDTH-1:0], 1'b0), k1));
        end
        for (int j = 0; j < `ECC_CHECK_WIDTH; j++) begin
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            send_word(flip_bit(encode(r[`ECC_DATA_WIDTH-1:0], 1'b0), `ECC_DATA_WIDTH + j));
        end
        for (int n = 0; n < 12; n++) begin      // two distinct bits anywhere
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            draw_bits(stim_lfsr, 14, r2);
            k1 = int'(r2[6:0]) % 91;
            k2 = (k1 + 1 + int'(r2[13:7]) % 90) % 91;
            w  = flip_bit(encode(r[`ECC_DATA_WIDTH-1:0], 1'b0), k1);
            send_word(flip_bit(w, k2));
        end
        for (int n = 0; n < 9; n++) begin       // bypass, 0 to 2 flips
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            w = encode(r[`ECC_DATA_WIDTH-1:0], 1'b1);
            if (n % 3 > 0) begin
                w = flip_bit(w, n * 7);
            end
            if (n % 3 > 1) begin
                w = flip_bit(w, n * 7 + 3);
            end
            send_word(w);
        end

        // back-pressure, only the initial grant may get out
        wait_drain();
        hold_credits = 1'b1;
        base         = words_recv;
        for (int n = 0; n < 6; n++) begin
            draw_bits(stim_lfsr, `ECC_DATA_WIDTH, r);
            send_word(encode(r[`ECC_DATA_WIDTH-1:0], 1'b0));
        end
        repeat (30) @(posedge clk);
        #1;
        compare("words out under hold", `ECC_OUT_CREDITS, words_recv - base);
        hold_credits = 1'b0;
        wait_drain();

        $display("checks %0d, value mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
hdl/ecc_code_pkg.sv
hdl/ecc_stream_pkg.sv
hdl/ecc_check_gen.sv
hdl/ecc_syndrome_decode.sv
hdl/ecc_result_fifo.sv
hdl/ecc_check_top.sv
bench/ecc_check_properties.sv
bench/ecc_check_tb.sv

// File: hdl/ecc_check_gen.sv
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_check_gen (
    input  ecc_code_pkg::ecc_data_t  data,
    output ecc_code_pkg::ecc_check_t check
);
    import ecc_code_pkg::*;

    // data bits that feed check bit j
    function automatic ecc_data_t select_bits(input int unsigned j);
        ecc_data_t  sel;
        ecc_check_t col;
        sel = '0;
        for (int unsigned i = 0; i < `ECC_DATA_WIDTH; i++) begin
            col    = ecc_column(i);
            sel[i] = col[j];
        end
        return sel;
    endfunction

    // ==========================================================================
    // one xor tree per check bit
    // ==========================================================================
    for (genvar j = 0; j < `ECC_CHECK_WIDTH; j++) begin : g_check
        localparam ecc_data_t sel = select_bits(j);

        assign check[j] = ^(data & sel);
    end

endmodule

// File: hdl/ecc_check_top.sv
`timescale 1ns/1ps

module ecc_check_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  ecc_stream_pkg::ecc_in_s  in_word,
    output logic                     in_credit,
    output logic                     out_valid,
    output ecc_stream_pkg::ecc_out_s out_word,
    input  logic                     out_credit
);
    import ecc_code_pkg::*;
    import ecc_stream_pkg::*;

    ecc_check_t    gen_check;       // recomputed from incoming data
    ecc_syndrome_u in_syndrome;

    logic          s1_valid;
    ecc_in_s       s1_word;
    ecc_check_t    s1_check;
    ecc_syndrome_u s1_syndrome;

    ecc_data_t     s1_mask;
    ecc_err_t      s1_err;
    ecc_out_s      s2_next;

    logic          s2_valid;
    ecc_out_s      s2_word;

    // ==========================================================================
    // stage 1: check bits and syndrome
    // ==========================================================================
    ecc_check_gen u_check_gen (
        .data  (in_word.data),
        .check (gen_check)
    );

    assign in_syndrome.raw = in_word.check ^ gen_check;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_word     <= in_word;
        s1_check    <= gen_check;
        s1_syndrome <= in_syndrome;
    end

    // ==========================================================================
    // stage 2: correction and error flags
    // ==========================================================================
    ecc_syndrome_decode u_decode (
        .syndrome (s1_syndrome),
        .mask     (s1_mask),
        .err      (s1_err)
    );

    always_comb begin
        s2_next.data     = s1_word.bypass ? s1_word.data : s1_word.data ^ s1_mask;
        s2_next.check    = s1_check;
        s2_next.sbit_err = !s1_word.bypass && (s1_err == ecc_single);
        s2_next.dbit_err = !s1_word.bypass && (s1_err == ecc_double);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_word <= s2_next;
    end

    // result buffer, credits both ways
    ecc_result_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (s2_valid),
        .push_word  (s2_word),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

endmodule

// File: hdl/ecc_code_pkg.sv
`include "ecc_config.svh"

package ecc_code_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]  ecc_data_t;
    typedef logic [`ECC_CHECK_WIDTH-1:0] ecc_check_t;

    // raw view for zero/weight tests, field view to locate the flipped bit
    typedef union packed {
        logic [`ECC_CHECK_WIDTH-1:0] raw;
        struct packed {
            logic                      overall;
            logic [`ECC_POS_WIDTH-1:0] position;
        } fields;
    } ecc_syndrome_u;

    typedef enum logic [1:0] {
        ecc_clean  = 2'd0,
        ecc_single = 2'd1,
        ecc_double = 2'd2
    } ecc_err_t;

    // ======================================================================
    // column code of data bit idx
    //   low bits: the (idx+1)-th non-power-of-two from 3 upward
    //   top bit : set when the position has even weight, so every column
    //             ends up with odd weight
    // ======================================================================
    function automatic ecc_check_t ecc_column(input int unsigned idx);
        int unsigned               pos;
        logic [`ECC_POS_WIDTH-1:0] p;
        ecc_check_t                col;
        pos = 2;
        for (int unsigned k = 0; k <= idx; k++) begin
            pos++;
            while ((pos & (pos - 1)) == 0) begin   // skip check-bit slots
                pos++;
            end
        end
        p   = pos[`ECC_POS_WIDTH-1:0];
        col = {~^p, p};
        return col;
    endfunction

endpackage

// File: hdl/ecc_result_fifo.sv
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_result_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  ecc_stream_pkg::ecc_out_s push_word,
    output logic                     out_valid,
    output ecc_stream_pkg::ecc_out_s out_word,
    input  logic                     out_credit,
    output logic                     in_credit
);
    import ecc_stream_pkg::*;

    localparam int PTR_W = $clog2(`ECC_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`ECC_FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(`ECC_OUT_CREDITS + 1);

    ecc_out_s         entries [`ECC_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;   // downstream grants not yet spent
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(`ECC_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // head leaves whenever the downstream can take it
    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign out_word  = entries[rd_ptr];

    // ==========================================================================
    // storage
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ==========================================================================
    // credits, downstream counter and upstream return
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits   <= CRD_W'(`ECC_OUT_CREDITS);
            in_credit <= 1'b0;
        end else begin
            case ({out_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            in_credit <= pop;   // one pulse per word popped
        end
    end

endmodule

// File: hdl/ecc_stream_pkg.sv
package ecc_stream_pkg;

    // word as received from upstream
    typedef struct packed {
        ecc_code_pkg::ecc_data_t  data;
        ecc_code_pkg::ecc_check_t check;
        logic                     bypass;   // pass through, no correction
    } ecc_in_s;

    // checked result
    typedef struct packed {
        ecc_code_pkg::ecc_data_t  data;       // corrected data
        ecc_code_pkg::ecc_check_t check;      // recomputed from received data
        logic                     sbit_err;
        logic                     dbit_err;
    } ecc_out_s;

endpackage

// File: hdl/ecc_syndrome_decode.sv
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_syndrome_decode (
    input  ecc_code_pkg::ecc_syndrome_u syndrome,
    output ecc_code_pkg::ecc_data_t     mask,
    output ecc_code_pkg::ecc_err_t      err
);
    import ecc_code_pkg::*;

    logic data_hit;     // syndrome matches a data column
    logic weight_one;   // a check bit alone flipped

    // ==========================================================================
    // column match, at most one bit of the mask can be set
    // ==========================================================================
    for (genvar i = 0; i < `ECC_DATA_WIDTH; i++) begin : g_col
        localparam ecc_check_t col = ecc_column(i);

        assign mask[i] = (syndrome.fields.position == col[`ECC_POS_WIDTH-1:0]) &&
                         (syndrome.fields.overall == col[`ECC_CHECK_WIDTH-1]);
    end

    assign data_hit   = |mask;
    assign weight_one = $onehot(syndrome.raw);

    // ==========================================================================
    // error class
    // ==========================================================================
    always_comb begin
        if (syndrome.raw == '0) begin
            err = ecc_clean;
        end else if (data_hit || weight_one) begin
            err = ecc_single;
        end else begin
            err = ecc_double;       // even weight or unused odd code
        end
    end

endmodule

// File: include/ecc_config.svh
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// ==========================================================================
// code geometry
// ==========================================================================
`define ECC_DATA_WIDTH  83
`define ECC_CHECK_WIDTH 8
`define ECC_POS_WIDTH   7   // hamming position, check bit 7 is overall parity

// ==========================================================================
// flow control
// ==========================================================================
`define ECC_FIFO_DEPTH  4   // result entries, also upstream credits at reset
`define ECC_OUT_CREDITS 2   // downstream grant after reset

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the ECC checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module ecc_check_tb \
    -Mdir obj_dir -o ecc_check_sim > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
    echo "build error, status $status"
    exit 1
fi

./obj_dir/ecc_check_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
